/* sources.f */
verilog/cache_pkg.sv
verilog/direct_cache.sv
verilog/mem_pipe.sv
verilog/cache_fill_fsm.sv
verilog/mem_system.sv
test/mem_system_asserts.sv
test/mem_system_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_system_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* test/mem_system_tb.sv */
`timescale 1ns/1ps

module mem_system_tb;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_OPS    = 84;
    localparam int OP_LIMIT   = 40;
    localparam int MISS_LAT   = 12;

    logic                clk;
    logic                i_arst_n;
    cache_pkg::cpu_req_t i_ireq;
    cache_pkg::cpu_req_t i_dreq;
    cache_pkg::cpu_rsp_t o_irsp;
    cache_pkg::cpu_rsp_t o_drsp;

    int          seed = 32'h4696;
    int          val_errs;
    int          timeouts;
    int          exp_ilat;
    int          exp_dlat;
    int          icnt;
    int          dcnt;
    int          idone_n;
    int          ddone_n;
    string       test_name;
    logic [15:0] ref_mem [logic [14:0]];
    logic [6:0]  ref_tag [2][32];  // Port 0 is the instruction cache.
    bit   [31:0] ref_vld [2];
    logic [15:0] preload_q [$];

    mem_system DUT (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_ireq   (i_ireq),
        .i_dreq   (i_dreq),
        .o_irsp   (o_irsp),
        .o_drsp   (o_drsp)
    );

    bind cache_fill_fsm mem_system_asserts fill_checks (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_init    (init),
        .i_mem_req (o_mem_req),
        .i_ifill   (o_ifill),
        .i_dfill   (o_dfill),
        .i_istall  (o_istall),
        .i_dstall  (o_dstall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [15:0] ref_read(input cache_pkg::addr_u a);
        if (ref_mem.exists(a.raw[15:1])) begin
            return ref_mem[a.raw[15:1]];
        end
        return 16'h0000;  // Main memory starts cleared.
    endfunction

    function automatic bit ref_hit(input int port, input cache_pkg::addr_u a);
        return ref_vld[port][a.f.index] && (ref_tag[port][a.f.index] == a.f.tag);
    endfunction

    task automatic check_rsp(input string name, input cache_pkg::cpu_rsp_t exp,
                             input cache_pkg::cpu_rsp_t act);
        if (act.rdata !== exp.rdata) begin
            $display("ERR %s: expected rdata %h, actual %h", name, exp.rdata, act.rdata);
            val_errs++;
        end
    endtask

    task automatic check_stall(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s: expected %0d stall cycles, actual %0d", name, exp, act);
            val_errs++;
        end
    endtask

    // --------------------
    // Compare at the rising edge. Inputs have been steady since the falling edge.
    always @(posedge clk) begin : compare
        cache_pkg::cpu_rsp_t exp_rsp;
        if (!i_ireq.en) begin
            icnt = 0;
        end else if (o_irsp.stall) begin
            icnt++;
        end else begin
            exp_rsp = '{rdata: ref_read(i_ireq.addr), stall: 1'b0};
            check_rsp(test_name, exp_rsp, o_irsp);
            check_stall(test_name, exp_ilat, icnt);
            icnt = 0;
            idone_n++;
        end
        if (!i_dreq.en) begin
            dcnt = 0;
        end else if (o_drsp.stall) begin
            dcnt++;
        end else if (i_dreq.wr) begin
            ref_mem[i_dreq.addr.raw[15:1]] = i_dreq.wdata;  // Write goes through to memory.
            dcnt = 0;
            ddone_n++;
        end else begin
            exp_rsp = '{rdata: ref_read(i_dreq.addr), stall: 1'b0};
            check_rsp(test_name, exp_rsp, o_drsp);
            check_stall(test_name, exp_dlat, dcnt);
            dcnt = 0;
            ddone_n++;
        end
    end

    // Each port drops its request on the falling edge after it has been served.
    task automatic wait_served(input string name, input int limit);
        int i0;
        int d0;
        int n;
        i0 = idone_n;
        d0 = ddone_n;
        n  = 0;
        while ((i_ireq.en || i_dreq.en) && n < limit) begin
            @(negedge clk);
            if (idone_n != i0) begin
                i_ireq.en = 1'b0;
            end
            if (ddone_n != d0) begin
                i_dreq.en = 1'b0;
            end
            n++;
        end
        if (i_ireq.en || i_dreq.en) begin
            $display("Timeout in %s: request still stalled after %0d cycles", name, limit);
            timeouts++;
            i_ireq.en = 1'b0;
            i_dreq.en = 1'b0;
        end
    endtask

    task automatic read_ports(input string name, input bit ien, input cache_pkg::addr_u ia,
                              input bit den, input cache_pkg::addr_u da);
        bit imiss;
        bit dmiss;
        imiss     = ien && !ref_hit(0, ia);
        dmiss     = den && !ref_hit(1, da);
        exp_ilat  = imiss ? MISS_LAT : 0;
        // A data fill behind an instruction fill starts one block of issues later.
        exp_dlat  = dmiss ? (imiss ? MISS_LAT + cache_pkg::WORDS_PER_BLOCK : MISS_LAT) : 0;
        test_name = name;
        i_ireq    = {ien, 1'b0, ia, 16'h0000};
        i_dreq    = {den, 1'b0, da, 16'h0000};
        wait_served(name, OP_LIMIT);
        if (imiss) begin
            ref_tag[0][ia.f.index] = ia.f.tag;
            ref_vld[0][ia.f.index] = 1'b1;
        end
        if (dmiss) begin
            ref_tag[1][da.f.index] = da.f.tag;
            ref_vld[1][da.f.index] = 1'b1;
        end
    endtask

    task automatic write_word(input string name, input cache_pkg::addr_u a,
                              input logic [15:0] d);
        test_name = name;
        i_dreq    = {1'b1, 1'b1, a, d};
        wait_served(name, MISS_LAT + 1);
    endtask

    initial begin : stimulus
        logic [15:0] a;
        int          k;
        int          asrt_fails;
        i_arst_n = 1'b0;
        i_ireq   = '0;
        i_dreq   = '0;
        repeat (16) @(negedge clk);
        i_arst_n = 1'b1;
        @(negedge clk);

        // Lower 2K bytes hold data blocks, the next 2K hold instruction blocks.
        for (k = 0; k < 64; k++) begin
            a = (16'($random(seed)) & 16'h07fe) | ((k >= 32) ? 16'h0800 : 16'h0000);
            write_word("preload", a, 16'($random(seed)));
            preload_q.push_back(a);
        end

        read_ports("dread_miss", 1'b0, 16'h0000, 1'b1, preload_q[0]);
        read_ports("dread_hit", 1'b0, 16'h0000, 1'b1, preload_q[0] ^ 16'h0002);
        for (k = 32; k < 36; k++) begin
            read_ports("ifetch_miss", 1'b1, preload_q[k], 1'b0, 16'h0000);
            read_ports("ifetch_hit", 1'b1, preload_q[k] ^ 16'h0004, 1'b0, 16'h0000);
        end
        read_ports("dual_miss", 1'b1, preload_q[40], 1'b1, preload_q[12]);

        for (k = 0; k < 6; k++) begin
            a = preload_q[8] ^ ((k % 2 == 1) ? 16'h0200 : 16'h0000);  // Same index, new tag.
            read_ports("conflict", 1'b0, 16'h0000, 1'b1, a);
        end

        read_ports("write_hit_fill", 1'b0, 16'h0000, 1'b1, preload_q[0]);
        write_word("write_hit_store", preload_q[0], 16'($random(seed)));
        read_ports("write_hit_read", 1'b0, 16'h0000, 1'b1, preload_q[0]);

        asrt_fails = DUT.fill_fsm.fill_checks.fails;
        $display("Errors: %0d value, %0d timeout, %0d assertion",
                 val_errs, timeouts, asrt_fails);
        if (val_errs + timeouts + asrt_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((16 + NUM_OPS * OP_LIMIT) * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time.");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* test/mem_system_asserts.sv */
`timescale 1ns/1ps

module mem_system_asserts (
    input logic                clk,
    input logic                i_arst_n,
    input logic                i_init,
    input cache_pkg::mem_req_t i_mem_req,
    input cache_pkg::fill_wr_t i_ifill,
    input cache_pkg::fill_wr_t i_dfill,
    input logic                i_istall,
    input logic                i_dstall
);

    int         fails = 0;
    logic [6:0] ihist;  // Data strobes of the previous seven cycles.
    logic [6:0] dhist;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ihist <= '0;
            dhist <= '0;
        end else begin
            ihist <= {ihist[5:0], i_ifill.data_we};
            dhist <= {dhist[5:0], i_dfill.data_we};
        end
    end

    rd_wr_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_mem_req.rd && i_mem_req.wr)) else begin
        $error("memory read and write requested in the same cycle");
        fails++;
    end

    // The first read of a fill starts the block.
    first_aligned: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_init |-> i_mem_req.rd && (i_mem_req.addr.raw[3:0] == 4'h0)) else begin
        $error("first fill read is not block aligned");
        fails++;
    end

    itag_after_data: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_ifill.tag_we |-> i_ifill.data_we && (&ihist)) else begin
        $error("instruction tag written without eight data writes");
        fails++;
    end

    dtag_after_data: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_dfill.tag_we |-> i_dfill.data_we && (&dhist)) else begin
        $error("data tag written without eight data writes");
        fails++;
    end

    reset_quiet: assert property (@(posedge clk)
        !i_arst_n |-> !i_istall && !i_dstall) else begin
        $error("stall raised during reset");
        fails++;
    end

endmodule

/* verilog/mem_system.sv */
`timescale 1ns/1ps

module mem_system (
    input  logic                clk,
    input  logic                i_arst_n,
    input  cache_pkg::cpu_req_t i_ireq,
    input  cache_pkg::cpu_req_t i_dreq,
    output cache_pkg::cpu_rsp_t o_irsp,
    output cache_pkg::cpu_rsp_t o_drsp
);

    cache_pkg::mem_req_t mem_req;
    cache_pkg::fill_wr_t ifill;
    cache_pkg::fill_wr_t dfill;
    logic [15:0]         mem_rdata;
    logic                mem_rvalid;
    logic [15:0]         irdata;
    logic [15:0]         drdata;
    logic                imiss;
    logic                dmiss;
    logic                istall;
    logic                dstall;

    direct_cache icache (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_req       (i_ireq),
        .i_fill      (ifill),
        .i_fill_data (mem_rdata),
        .o_rdata     (irdata),
        .o_miss      (imiss)
    );

    direct_cache dcache (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_req       (i_dreq),
        .i_fill      (dfill),
        .i_fill_data (mem_rdata),
        .o_rdata     (drdata),
        .o_miss      (dmiss)
    );

    cache_fill_fsm fill_fsm (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_imiss   (imiss),
        .i_dmiss   (dmiss),
        .i_ireq    (i_ireq),
        .i_dreq    (i_dreq),
        .i_rvalid  (mem_rvalid),
        .o_mem_req (mem_req),
        .o_ifill   (ifill),
        .o_dfill   (dfill),
        .o_istall  (istall),
        .o_dstall  (dstall)
    );

    mem_pipe main_mem (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_req    (mem_req),
        .o_rdata  (mem_rdata),
        .o_rvalid (mem_rvalid)
    );

    // Read data comes straight from the arrays. The stall says whether it counts.
    assign o_irsp = '{rdata: irdata, stall: istall};
    assign o_drsp = '{rdata: drdata, stall: dstall};

endmodule

/* verilog/cache_fill_fsm.sv */
`timescale 1ns/1ps

module cache_fill_fsm (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_imiss,
    input  logic                i_dmiss,
    input  cache_pkg::cpu_req_t i_ireq,
    input  cache_pkg::cpu_req_t i_dreq,
    input  logic                i_rvalid,
    output cache_pkg::mem_req_t o_mem_req,
    output cache_pkg::fill_wr_t o_ifill,
    output cache_pkg::fill_wr_t o_dfill,
    output logic                o_istall,
    output logic                o_dstall
);

    localparam int W      = cache_pkg::WORDS_PER_BLOCK;
    localparam int L      = cache_pkg::MEM_LATENCY;
    localparam int STAGES = W + L;
    localparam logic IDLE = 1'b0;
    localparam logic WAIT = 1'b1;

    logic              state_q;
    logic [STAGES-1:1] issue_q;
    logic [STAGES-1:0] stage;       // Stage k is active in cycle k of a fill.
    logic              init;
    logic              new_sel;
    logic              cur_sel;
    logic              addr_sel_q;  // Cache served by the address stream, 1 is the data cache.
    logic              data_sel_q;  // Cache that owns the returning words.
    logic              wr_ok;
    logic              ret_we;
    logic [2:0]        ret_off;
    logic [2:0]        issue_off;
    cache_pkg::addr_u  blk_addr;

    function automatic logic [2:0] onehot_idx(input logic [7:0] oh);
        logic [2:0] idx;
        int         k;
        idx = '0;
        for (k = 0; k < 8; k++) begin
            if (oh[k]) begin
                idx = idx | 3'(k);
            end
        end
        return idx;
    endfunction

    assign stage = {issue_q, init};

    // --------------------
    // Fill start.
    // A fill starts from idle, or at stage W of a running fill when the other cache waits.
    always_comb begin
        init    = 1'b0;
        new_sel = 1'b0;
        if (state_q == IDLE) begin
            init    = i_imiss | i_dmiss;
            new_sel = ~i_imiss;  // Instruction misses go first.
        end else if (issue_q[W]) begin
            new_sel = ~addr_sel_q;
            init    = addr_sel_q ? i_imiss : i_dmiss;
        end
    end

    assign cur_sel   = init ? new_sel : addr_sel_q;
    assign blk_addr  = cur_sel ? i_dreq.addr : i_ireq.addr;
    assign issue_off = onehot_idx(stage[W-1:0]);
    assign wr_ok     = (state_q == IDLE) && !i_imiss && !i_dmiss;

    // --------------------
    // Memory requests.
    always_comb begin
        o_mem_req       = '0;
        o_mem_req.wdata = i_dreq.wdata;
        if (|stage[W-1:0]) begin
            o_mem_req.rd            = 1'b1;
            o_mem_req.addr.f.tag    = blk_addr.f.tag;
            o_mem_req.addr.f.index  = blk_addr.f.index;
            o_mem_req.addr.f.offset = issue_off;
        end
        if (wr_ok && i_dreq.en && i_dreq.wr) begin
            o_mem_req.wr   = 1'b1;  // Write-through, taken only when idle.
            o_mem_req.addr = i_dreq.addr;
        end
    end

    // --------------------
    // Fill strobes.
    assign ret_we  = i_rvalid && (|stage[STAGES-1:L]);
    assign ret_off = onehot_idx(stage[STAGES-1:L]);

    assign o_ifill.data_we = ret_we && !data_sel_q;
    assign o_ifill.tag_we  = stage[STAGES-1] && !data_sel_q;
    assign o_ifill.offset  = ret_off;
    assign o_dfill.data_we = ret_we && data_sel_q;
    assign o_dfill.tag_we  = stage[STAGES-1] && data_sel_q;
    assign o_dfill.offset  = ret_off;

    assign o_istall = i_imiss;
    assign o_dstall = i_dmiss || (i_dreq.en && i_dreq.wr && !wr_ok);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= IDLE;
            issue_q    <= '0;
            addr_sel_q <= 1'b0;
            data_sel_q <= 1'b0;
        end else begin
            state_q <= (|stage[STAGES-2:0]) ? WAIT : IDLE;
            issue_q <= stage[STAGES-2:0];
            if (init) begin
                addr_sel_q <= new_sel;
            end
            // The data flag follows the address flag once the last word of a block is in.
            if (init && state_q == IDLE) begin
                data_sel_q <= new_sel;
            end else if (stage[STAGES-1]) begin
                data_sel_q <= addr_sel_q;
            end
        end
    end

endmodule

/* verilog/mem_pipe.sv */
`timescale 1ns/1ps

module mem_pipe (
    input  logic                clk,
    input  logic                i_arst_n,
    input  cache_pkg::mem_req_t i_req,
    output logic [15:0]         o_rdata,
    output logic                o_rvalid
);

    localparam int L     = cache_pkg::MEM_LATENCY;
    localparam int DEPTH = 32768;

    logic [15:0]  mem [DEPTH];
    logic [L-1:0] vld_q;
    logic [15:0]  data_q [L];
    logic [14:0]  word_addr;

    assign word_addr = i_req.addr.raw[15:1];

    initial begin
        int i;
        for (i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (i_req.wr) begin
            mem[word_addr] <= i_req.wdata;
        end
    end

    // --------------------
    // Read pipeline, one word per cycle in order.
    always_ff @(posedge clk) begin
        if (i_req.rd) begin
            data_q[0] <= mem[word_addr];
        end
        for (int s = 1; s < L; s++) begin
            data_q[s] <= data_q[s-1];
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[L-2:0], i_req.rd};
        end
    end

    assign o_rvalid = vld_q[L-1];
    assign o_rdata  = data_q[L-1];

endmodule

/* verilog/direct_cache.sv */
`timescale 1ns/1ps

module direct_cache (
    input  logic                clk,
    input  logic                i_arst_n,
    input  cache_pkg::cpu_req_t i_req,
    input  cache_pkg::fill_wr_t i_fill,
    input  logic [15:0]         i_fill_data,
    output logic [15:0]         o_rdata,
    output logic                o_miss
);

    localparam int SETS  = cache_pkg::NUM_SETS;
    localparam int WORDS = SETS * cache_pkg::WORDS_PER_BLOCK;

    logic [6:0]      tag_mem  [SETS];
    logic [SETS-1:0] valid_q;
    logic [15:0]     data_mem [WORDS];
    logic [4:0]      idx;
    logic [7:0]      rd_word;
    logic [7:0]      fill_word;
    logic            hit;

    assign idx       = i_req.addr.f.index;
    assign rd_word   = {idx, i_req.addr.f.offset};
    assign fill_word = {idx, i_fill.offset};

    assign hit     = valid_q[idx] && (tag_mem[idx] == i_req.addr.f.tag);
    assign o_miss  = i_req.en && !i_req.wr && !hit;  // Writes never allocate.
    assign o_rdata = data_mem[rd_word];

    // --------------------
    // Tag and valid arrays.
    always_ff @(posedge clk) begin
        if (i_fill.tag_we) begin
            tag_mem[idx] <= i_req.addr.f.tag;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
        end else if (i_fill.tag_we) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // --------------------
    // Data array.
    always_ff @(posedge clk) begin
        if (i_fill.data_we) begin
            data_mem[fill_word] <= i_fill_data;
        end else if (i_req.en && i_req.wr && hit) begin
            data_mem[rd_word] <= i_req.wdata;  // Write hit keeps the line in step with memory.
        end
    end

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

    // --------------------
    // Geometry and timing.
    localparam int WORDS_PER_BLOCK = 8;
    localparam int MEM_LATENCY     = 4;
    localparam int NUM_SETS        = 32;

    // --------------------
    // Byte address, seen as a raw word or as cache fields.
    typedef struct packed {
        logic [6:0] tag;
        logic [4:0] index;
        logic [2:0] offset;    // Word within the block.
        logic       byte_sel;  // Not used, all accesses are 16-bit words.
    } addr_fields_t;

    typedef union packed {
        logic [15:0]  raw;
        addr_fields_t f;
    } addr_u;

    // --------------------
    // Port and memory bundles.
    typedef struct packed {
        logic        en;
        logic        wr;     // Only the data port ever writes.
        addr_u       addr;
        logic [15:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        stall;
    } cpu_rsp_t;

    typedef struct packed {
        logic        rd;
        logic        wr;
        addr_u       addr;
        logic [15:0] wdata;
    } mem_req_t;

    // The fill word is the memory read data. Tag and index come from the cache's own request.
    typedef struct packed {
        logic       data_we;
        logic       tag_we;
        logic [2:0] offset;
    } fill_wr_t;

endpackage
